/* hazardPkg.sv */
package hazardPkg;

    ////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opJal  = 6'h03;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opBne  = 6'h05;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opAndi = 6'h0c;
    localparam logic [5:0] opOri  = 6'h0d;
    localparam logic [5:0] opLui  = 6'h0f;
    localparam logic [5:0] opLb   = 6'h20;
    localparam logic [5:0] opLh   = 6'h21;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSb   = 6'h28;
    localparam logic [5:0] opSh   = 6'h29;
    localparam logic [5:0] opSw   = 6'h2b;

    // R-type function codes
    localparam logic [5:0] fnJr    = 6'h08;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    ////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////
    typedef logic [4:0] regNum_t;
    typedef logic [1:0] stageT_t;

    // Same word, read as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [5:0] op;
            regNum_t    rs;
            regNum_t    rt;
            regNum_t    rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rView;
        struct packed {
            logic [5:0]  op;
            regNum_t     rs;
            regNum_t     rt;
            logic [15:0] imm;
        } iView;
    } instrWord_t;

    localparam regNum_t linkReg = 5'd31;

    // HI/LO busy periods
    localparam int unsigned mdCountW = 4;
    localparam logic [mdCountW-1:0] multCycles = 4'd5;
    localparam logic [mdCountW-1:0] divCycles  = 4'd10;

endpackage

/* useDecoder.sv */
`timescale 1ns/100ps

module useDecoder import hazardPkg::*; (
    input  instrWord_t instrD,
    output regNum_t    numUseRs,
    output regNum_t    numUseRt,
    output stageT_t    tuseRs,
    output stageT_t    tuseRt
);

    always_comb begin
        // Unread sources carry register zero
        numUseRs = '0;
        numUseRt = '0;
        tuseRs   = 2'd0;
        tuseRt   = 2'd0;

        case (instrD.rView.op)
            opR: begin
                case (instrD.rView.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                    fnMult, fnMultu, fnDiv, fnDivu: begin
                        numUseRs = instrD.rView.rs;
                        numUseRt = instrD.rView.rt;
                        tuseRs   = 2'd1;
                        tuseRt   = 2'd1;
                    end
                    fnMthi, fnMtlo: begin
                        numUseRs = instrD.rView.rs;
                        tuseRs   = 2'd1;
                    end
                    fnJr: begin
                        // Jump target needed in decode
                        numUseRs = instrD.rView.rs;
                        tuseRs   = 2'd0;
                    end
                    default: begin
                        numUseRs = '0;
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLw, opLb, opLh: begin
                numUseRs = instrD.iView.rs;
                tuseRs   = 2'd1;
            end

            opSw, opSb, opSh: begin
                // Store data is not needed until memory
                numUseRs = instrD.iView.rs;
                numUseRt = instrD.iView.rt;
                tuseRs   = 2'd1;
                tuseRt   = 2'd2;
            end

            opBeq, opBne: begin
                numUseRs = instrD.iView.rs;
                numUseRt = instrD.iView.rt;
                tuseRs   = 2'd0;
                tuseRt   = 2'd0;
            end

            // Lui, j and jal read no register
            default: begin
                numUseRs = '0;
                numUseRt = '0;
            end
        endcase
    end

endmodule

/* newDecoder.sv */
`timescale 1ns/100ps

module newDecoder import hazardPkg::*; (
    input  instrWord_t instrE,
    output regNum_t    numNewE,
    output stageT_t    tnewE
);

    always_comb begin
        numNewE = '0;
        tnewE   = 2'd0;

        case (instrE.rView.op)
            opR: begin
                case (instrE.rView.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                    fnMfhi, fnMflo: begin
                        numNewE = instrE.rView.rd;
                        tnewE   = 2'd1;
                    end
                    // Mult, div, mthi, mtlo and jr leave the GPRs alone
                    default: begin
                        numNewE = '0;
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLui: begin
                numNewE = instrE.iView.rt;
                tnewE   = 2'd1;
            end

            opLw, opLb, opLh: begin
                // Load data arrives after memory
                numNewE = instrE.iView.rt;
                tnewE   = 2'd2;
            end

            opJal: begin
                numNewE = linkReg;
                tnewE   = 2'd0;
            end

            default: begin
                numNewE = '0;
                tnewE   = 2'd0;
            end
        endcase
    end

endmodule

/* newTracker.sv */
`timescale 1ns/100ps

module newTracker import hazardPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  regNum_t numNewE,
    input  stageT_t tnewE,
    output regNum_t numNewM,
    output stageT_t tnewM
);

    stageT_t tnewAged;

    // One cycle closer to ready, floor at zero
    assign tnewAged = (tnewE == 2'd0) ? 2'd0 : tnewE - 2'd1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            numNewM <= '0;
            tnewM   <= 2'd0;
        end else begin
            numNewM <= numNewE;
            tnewM   <= tnewAged;
        end
    end

endmodule

/* mulDivTimer.sv */
`timescale 1ns/100ps

module mulDivTimer import hazardPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  instrWord_t instrE,
    output logic       mdStart,
    output logic       mdBusy
);

    logic [mdCountW-1:0] mdCount;
    logic                isMul;
    logic                isDiv;

    always_comb begin
        isMul = 1'b0;
        isDiv = 1'b0;
        if (instrE.rView.op == opR) begin
            case (instrE.rView.funct)
                fnMult, fnMultu: isMul = 1'b1;
                fnDiv, fnDivu:   isDiv = 1'b1;
                default:         isMul = 1'b0;
            endcase
        end
    end

    assign mdBusy  = (mdCount != '0);
    assign mdStart = (isMul | isDiv) & ~mdBusy;

    // Busy while the down-counter is non-zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdCount <= '0;
        end else if (mdStart) begin
            mdCount <= isDiv ? divCycles : multCycles;
        end else if (mdBusy) begin
            mdCount <= mdCount - mdCountW'(1);
        end
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit import hazardPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  instrWord_t instrD,
    input  instrWord_t instrE,
    output logic       pcWrite,
    output logic       ifIdEn,
    output logic       idExClr,
    output regNum_t    tuseRsD,
    output regNum_t    tuseRtD,
    output stageT_t    tnewE,
    output stageT_t    tnewM,
    output logic       mdBusy
);

    regNum_t numUseRs;
    regNum_t numUseRt;
    stageT_t tuseRs;
    stageT_t tuseRt;
    regNum_t numNewE;
    regNum_t numNewM;
    logic    mdStart;
    logic    stall;

    // Source still waits on a pending write
    function automatic logic srcStall(regNum_t num, stageT_t tuse);
        logic hitE;
        logic hitM;
        hitE = (num == numNewE) && (tuse < tnewE);
        hitM = (num == numNewM) && (tuse < tnewM);
        return (num != '0) && (hitE || hitM);
    endfunction

    useDecoder useDec (
        .instrD   (instrD),
        .numUseRs (numUseRs),
        .numUseRt (numUseRt),
        .tuseRs   (tuseRs),
        .tuseRt   (tuseRt)
    );

    newDecoder newDec (
        .instrE  (instrE),
        .numNewE (numNewE),
        .tnewE   (tnewE)
    );

    newTracker newTrk (
        .clk     (clk),
        .arstN   (arstN),
        .numNewE (numNewE),
        .tnewE   (tnewE),
        .numNewM (numNewM),
        .tnewM   (tnewM)
    );

    mulDivTimer mdTimer (
        .clk     (clk),
        .arstN   (arstN),
        .instrE  (instrE),
        .mdStart (mdStart),
        .mdBusy  (mdBusy)
    );

    ////////////////////////////////////////////////////////////
    // Stall decision
    ////////////////////////////////////////////////////////////
    always_comb begin
        stall = srcStall(numUseRs, tuseRs) | srcStall(numUseRt, tuseRt) |
                mdStart | mdBusy;
    end

    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    assign tuseRsD = numUseRs;
    assign tuseRtD = numUseRt;

endmodule

/* stageRegs.sv */
`timescale 1ns/100ps

module stageRegs import hazardPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  instrWord_t instrF,
    input  logic       ifIdEn,
    input  logic       idExClr,
    output instrWord_t instrD,
    output instrWord_t instrE
);

    // IF/ID holds its word while stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD <= '0;
        end else if (ifIdEn) begin
            instrD <= instrF;
        end
    end

    // ID/EX takes a nop bubble on clear
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrE <= '0;
        end else if (idExClr) begin
            instrE <= '0;
        end else begin
            instrE <= instrD;
        end
    end

endmodule

/* hazardPipe.sv */
`timescale 1ns/100ps

module hazardPipe import hazardPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  instrWord_t instrF,
    output logic       pcWrite,
    output logic       ifIdEn,
    output logic       idExClr,
    output regNum_t    tuseRsD,
    output regNum_t    tuseRtD,
    output stageT_t    tnewE,
    output stageT_t    tnewM,
    output logic       mdBusy
);

    instrWord_t instrD;
    instrWord_t instrE;

    stageRegs stages (
        .clk     (clk),
        .arstN   (arstN),
        .instrF  (instrF),
        .ifIdEn  (ifIdEn),
        .idExClr (idExClr),
        .instrD  (instrD),
        .instrE  (instrE)
    );

    hazardUnit hazard (
        .clk     (clk),
        .arstN   (arstN),
        .instrD  (instrD),
        .instrE  (instrE),
        .pcWrite (pcWrite),
        .ifIdEn  (ifIdEn),
        .idExClr (idExClr),
        .tuseRsD (tuseRsD),
        .tuseRtD (tuseRtD),
        .tnewE   (tnewE),
        .tnewM   (tnewM),
        .mdBusy  (mdBusy)
    );

endmodule

/* tbHazard.sv */
`timescale 1ns/100ps

module tbHazard import hazardPkg::*; ();

    localparam int clkPeriod     = 40;
    localparam int randomCount   = 400;
    localparam int plannedInstrs = randomCount + 140;
    localparam int worstCpi      = 11;
    localparam logic [31:0] nop  = 32'h0000_0000;

    // Instruction classes of the reference decode
    localparam int clsNone     = 0;
    localparam int clsAluR     = 1;
    localparam int clsMd       = 2;
    localparam int clsMoveTo   = 3;
    localparam int clsMoveFrom = 4;
    localparam int clsJr       = 5;
    localparam int clsAluI     = 6;
    localparam int clsLui      = 7;
    localparam int clsLoad     = 8;
    localparam int clsStore    = 9;
    localparam int clsBranch   = 10;
    localparam int clsJal      = 11;

    logic        clk;
    logic        arstN;
    logic [31:0] instrF;
    logic        pcWrite;
    logic        ifIdEn;
    logic        idExClr;
    regNum_t     tuseRsD;
    regNum_t     tuseRtD;
    stageT_t     tnewE;
    stageT_t     tnewM;
    logic        mdBusy;

    string       testName;
    int          valueErrors;
    int          otherErrors;
    int          stallCycles;

    // Reference model state
    logic [31:0] mD;
    logic [31:0] mE;
    logic [4:0]  mNumM;
    logic [1:0]  mTnewM;
    logic [3:0]  mCount;

    // Reference model outputs
    logic [4:0]  expRs;
    logic [4:0]  expRt;
    logic [4:0]  expNumE;
    logic [1:0]  expTnewE;
    logic        expMdStart;
    logic        expMdBusy;
    logic        expStall;

    hazardPipe dut0 (
        .clk     (clk),
        .arstN   (arstN),
        .instrF  (instrF),
        .pcWrite (pcWrite),
        .ifIdEn  (ifIdEn),
        .idExClr (idExClr),
        .tuseRsD (tuseRsD),
        .tuseRtD (tuseRtD),
        .tnewE   (tnewE),
        .tnewM   (tnewM),
        .mdBusy  (mdBusy)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference decode tables
    ////////////////////////////////////////////////////////////
    function automatic int classOf(input logic [31:0] w);
        logic [5:0] op;
        logic [5:0] fn;
        op = w[31:26];
        fn = w[5:0];
        if (op == opR) begin
            if (fn inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu}) return clsAluR;
            if (fn inside {fnMult, fnMultu, fnDiv, fnDivu}) return clsMd;
            if (fn inside {fnMthi, fnMtlo}) return clsMoveTo;
            if (fn inside {fnMfhi, fnMflo}) return clsMoveFrom;
            if (fn == fnJr) return clsJr;
            return clsNone;
        end
        if (op inside {opOri, opAddi, opAndi}) return clsAluI;
        if (op == opLui) return clsLui;
        if (op inside {opLw, opLb, opLh}) return clsLoad;
        if (op inside {opSw, opSb, opSh}) return clsStore;
        if (op inside {opBeq, opBne}) return clsBranch;
        if (op == opJal) return clsJal;
        return clsNone;
    endfunction

    function automatic logic [4:0] rsNum(input logic [31:0] w);
        int c;
        c = classOf(w);
        if (c inside {clsAluR, clsMd, clsMoveTo, clsJr, clsAluI, clsLoad, clsStore, clsBranch})
            return w[25:21];
        return 5'd0;
    endfunction

    function automatic logic [4:0] rtNum(input logic [31:0] w);
        int c;
        c = classOf(w);
        if (c inside {clsAluR, clsMd, clsStore, clsBranch}) return w[20:16];
        return 5'd0;
    endfunction

    // Decode-stage need times
    function automatic logic [1:0] rsTuse(input logic [31:0] w);
        return (classOf(w) inside {clsJr, clsBranch}) ? 2'd0 : 2'd1;
    endfunction

    function automatic logic [1:0] rtTuse(input logic [31:0] w);
        int c;
        c = classOf(w);
        if (c == clsStore) return 2'd2;
        if (c == clsBranch) return 2'd0;
        return 2'd1;
    endfunction

    function automatic logic [4:0] destNum(input logic [31:0] w);
        int c;
        c = classOf(w);
        if (c inside {clsAluR, clsMoveFrom}) return w[15:11];
        if (c inside {clsAluI, clsLui, clsLoad}) return w[20:16];
        if (c == clsJal) return 5'd31;
        return 5'd0;
    endfunction

    function automatic logic [1:0] destTnew(input logic [31:0] w);
        int c;
        c = classOf(w);
        if (c == clsLoad) return 2'd2;
        if (c inside {clsAluR, clsMoveFrom, clsAluI, clsLui}) return 2'd1;
        return 2'd0;
    endfunction

    function automatic logic [3:0] mdLatency(input logic [31:0] w);
        if (classOf(w) != clsMd) return 4'd0;
        return (w[5:0] inside {fnDiv, fnDivu}) ? 4'd10 : 4'd5;
    endfunction

    function automatic logic waitsOn(input logic [4:0] num, input logic [1:0] tuse);
        if (num == 5'd0) return 1'b0;
        return (num == expNumE && tuse < expTnewE) || (num == mNumM && tuse < mTnewM);
    endfunction

    always_comb begin
        expRs      = rsNum(mD);
        expRt      = rtNum(mD);
        expNumE    = destNum(mE);
        expTnewE   = destTnew(mE);
        expMdBusy  = (mCount != 4'd0);
        expMdStart = (mdLatency(mE) != 4'd0) && !expMdBusy;
        expStall   = waitsOn(expRs, rsTuse(mD)) || waitsOn(expRt, rtTuse(mD)) ||
                     expMdStart || expMdBusy;
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mD     <= '0;
            mE     <= '0;
            mNumM  <= '0;
            mTnewM <= '0;
            mCount <= '0;
        end else begin
            mD     <= expStall ? mD : instrF;
            mE     <= expStall ? 32'd0 : mD;
            mNumM  <= expNumE;
            mTnewM <= (expTnewE == 2'd0) ? 2'd0 : expTnewE - 2'd1;
            if (expMdStart)
                mCount <= mdLatency(mE);
            else if (expMdBusy)
                mCount <= mCount - 4'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////
    chkPcWrite: assert property (@(posedge clk) disable iff (!arstN) pcWrite == !expStall)
        else begin
            $display("FAIL %s pcWrite expected %0d actual %0d",
                     testName, !$sampled(expStall), $sampled(pcWrite));
            valueErrors++;
        end

    chkIfIdEn: assert property (@(posedge clk) disable iff (!arstN) ifIdEn == !expStall)
        else begin
            $display("FAIL %s ifIdEn expected %0d actual %0d",
                     testName, !$sampled(expStall), $sampled(ifIdEn));
            valueErrors++;
        end

    chkIdExClr: assert property (@(posedge clk) disable iff (!arstN) idExClr == expStall)
        else begin
            $display("FAIL %s idExClr expected %0d actual %0d",
                     testName, $sampled(expStall), $sampled(idExClr));
            valueErrors++;
        end

    chkTnewE: assert property (@(posedge clk) disable iff (!arstN) tnewE == expTnewE)
        else begin
            $display("FAIL %s tnewE expected %0d actual %0d",
                     testName, $sampled(expTnewE), $sampled(tnewE));
            valueErrors++;
        end

    chkTnewM: assert property (@(posedge clk) disable iff (!arstN) tnewM == mTnewM)
        else begin
            $display("FAIL %s tnewM expected %0d actual %0d",
                     testName, $sampled(mTnewM), $sampled(tnewM));
            valueErrors++;
        end

    chkMdBusy: assert property (@(posedge clk) disable iff (!arstN) mdBusy == expMdBusy)
        else begin
            $display("FAIL %s mdBusy expected %0d actual %0d",
                     testName, $sampled(expMdBusy), $sampled(mdBusy));
            valueErrors++;
        end

    chkSources: assert property (@(posedge clk) disable iff (!arstN)
                                 tuseRsD == expRs && tuseRtD == expRt)
        else begin
            $display("FAIL %s sources expected %0d/%0d actual %0d/%0d", testName,
                     $sampled(expRs), $sampled(expRt), $sampled(tuseRsD), $sampled(tuseRtD));
            valueErrors++;
        end

    // A stall holds decode and sends a bubble on
    chkBubble: assert property (@(posedge clk) disable iff (!arstN) idExClr |=> tnewE == 2'd0)
        else begin
            $display("%s: execute stage did not get a bubble after a stall", testName);
            otherErrors++;
        end

    chkHold: assert property (@(posedge clk) disable iff (!arstN) idExClr |=> $stable(dut0.instrD))
        else begin
            $display("%s: decode word changed during a stall", testName);
            otherErrors++;
        end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {opR, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Offer a word until the pipeline takes it, as a PC would
    task automatic feed(input logic [31:0] w);
        logic taken;
        instrF = w;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = pcWrite;
            if (!taken)
                stallCycles++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic runCase(input string name, input logic [31:0] a, input logic [31:0] b,
                           input int expStalls);
        testName = name;
        repeat (3) feed(nop);
        stallCycles = 0;
        feed(a);
        feed(b);
        repeat (3) feed(nop);
        assert (stallCycles == expStalls)
            else begin
                $display("FAIL %s stall cycles expected %0d actual %0d",
                         name, expStalls, stallCycles);
                valueErrors++;
            end
    endtask

    function automatic logic [31:0] randomInstr();
        logic [4:0]  a;
        logic [4:0]  b;
        logic [4:0]  c;
        logic [15:0] imm;
        int          sel;
        a   = 5'($urandom % 4);
        b   = 5'($urandom % 4);
        c   = 5'($urandom % 4);
        imm = 16'($urandom);
        sel = $urandom % 3;
        case ($urandom % 12)
            0, 1: return rWord(a, b, c, sel == 0 ? fnAdd : (sel == 1 ? fnSub : fnSlt));
            2:    return rWord(a, b, c, sel == 0 ? fnAnd : (sel == 1 ? fnOr : fnSltu));
            3:    return iWord(sel == 0 ? opOri : (sel == 1 ? opAddi : opAndi), a, b, imm);
            4:    return iWord(opLui, 5'd0, b, imm);
            5:    return iWord(sel == 0 ? opLw : (sel == 1 ? opLb : opLh), a, b, imm);
            6:    return iWord(sel == 0 ? opSw : (sel == 1 ? opSb : opSh), a, b, imm);
            7:    return iWord(sel == 0 ? opBeq : opBne, a, b, imm);
            8:    return rWord(a, b, 5'd0, sel == 0 ? fnMult : (sel == 1 ? fnDivu : fnMultu));
            9:    return rWord(sel == 0 ? a : 5'd0, 5'd0, sel == 0 ? 5'd0 : c,
                               sel == 0 ? fnMthi : (sel == 1 ? fnMfhi : fnMflo));
            10:   return {sel == 0 ? opJ : opJal, 26'h40};
            default: return rWord(a, 5'd0, 5'd0, fnJr);
        endcase
    endfunction

    initial begin
        void'($urandom(32'hc555));
        valueErrors = 0;
        otherErrors = 0;
        stallCycles = 0;
        testName    = "reset";
        instrF      = '0;
        arstN       = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arstN = 1'b1;
        @(negedge clk);
        assert (pcWrite && ifIdEn && !idExClr && !mdBusy)
            else begin
                $display("reset: stall controls are not idle after reset");
                otherErrors++;
            end
        @(posedge clk);
        #2;

        runCase("aluThenAlu", rWord(1, 2, 3, fnAdd), rWord(3, 1, 2, fnSub), 0);
        runCase("aluThenStore", rWord(1, 2, 3, fnOr), iWord(opSw, 3, 3, 16'h4), 0);
        runCase("loadThenStoreData", iWord(opLw, 1, 2, 16'h8), iWord(opSw, 1, 2, 16'h0), 0);
        runCase("loadThenAlu", iWord(opLw, 1, 2, 16'h8), rWord(2, 1, 3, fnAdd), 1);
        runCase("loadThenBeq", iWord(opLh, 1, 2, 16'h2), iWord(opBeq, 2, 1, 16'h1), 2);
        runCase("aluThenBeq", iWord(opAddi, 1, 2, 16'h1), iWord(opBne, 1, 2, 16'h1), 1);
        runCase("writeR0", iWord(opLw, 1, 0, 16'h0), iWord(opBeq, 0, 0, 16'h1), 0);
        runCase("jalThenJr", {opJal, 26'h100}, rWord(31, 0, 0, fnJr), 0);
        runCase("noWriter", iWord(opSw, 1, 2, 16'h0), iWord(opBeq, 2, 1, 16'h1), 0);
        runCase("multBusy", rWord(1, 2, 0, fnMult), nop, 1 + int'(multCycles));
        runCase("divBusy", rWord(1, 2, 0, fnDiv), nop, 1 + int'(divCycles));
        runCase("multThenAlu", rWord(1, 2, 0, fnMultu), rWord(1, 2, 3, fnAnd),
                1 + int'(multCycles));

        testName = "randomStream";
        for (int i = 0; i < randomCount; i++)
            feed(randomInstr());
        repeat (4) feed(nop);

        @(negedge clk);
        $display("Summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized for every instruction at worst-case CPI
    initial begin
        #((plannedInstrs * worstCpi + 100) * clkPeriod);
        $display("Run timed out in %s before all instructions were issued", testName);
        $display("Test failed");
        $finish;
    end

endmodule

/* hazardPipe.f */
hazardPkg.sv
useDecoder.sv
newDecoder.sv
newTracker.sv
mulDivTimer.sv
hazardUnit.sv
stageRegs.sv
hazardPipe.sv
tbHazard.sv

/* Makefile */
TOP = tbHazard
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f hazardPipe.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || { echo "Simulation failed"; exit 1; }

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f hazardPipe.f

clean:
	rm -rf obj_dir $(LOG)
